// ==== verilog/rename_cfg_pkg.sv ====
//**************************************************
// rename_cfg_pkg
// register file, reorder buffer and free list sizes
// tag and index types, reset mapping constants
//**************************************************

`default_nettype none

package rename_cfg_pkg;

  // architectural and physical register files
  localparam int num_arch = 32;
  localparam int arch_w   = 5;
  localparam int num_pr   = 64;
  localparam int pr_w     = 6;

  // reorder buffer
  localparam int num_rob = 16;
  localparam int rob_w   = 4;

  // free list holds every tag not mapped at reset
  localparam int num_free  = num_pr - num_arch;
  localparam int free_w    = 5;
  localparam int free_base = num_arch;

  typedef logic [arch_w-1:0] arch_reg_t;
  typedef logic [pr_w-1:0]   phys_tag_t;
  typedef logic [rob_w-1:0]  rob_idx_t;

endpackage

`default_nettype wire

// ==== verilog/rob_pkg.sv ====
//**************************************************
// rob_pkg
// dispatch, rename, retire and recovery structs
// reorder buffer entry layout
//**************************************************

`default_nettype none

package rob_pkg;

  import rename_cfg_pkg::*;

  // one instruction offered at dispatch
  typedef struct packed {
    logic      valid;
    arch_reg_t dest;
    logic      is_branch;
  } dispatch_req_t;

  // rename result, valid together with dispatch_fire
  typedef struct packed {
    phys_tag_t T;
    phys_tag_t T_old;
    arch_reg_t dest;
    rob_idx_t  rob_idx;
  } rename_t;

  typedef struct packed {
    logic      valid;
    arch_reg_t dest;
    phys_tag_t T;
    phys_tag_t T_old;
  } rob_entry_t;

  // head entry leaving the reorder buffer
  typedef struct packed {
    logic      valid;
    arch_reg_t dest;
    phys_tag_t T;
    phys_tag_t T_old;
  } retire_t;

  typedef struct packed {
    logic     mispredict;
    rob_idx_t branch_idx;
  } recover_t;

endpackage

`default_nettype wire

// ==== verilog/free_list.sv ====
//**************************************************
// free_list
// circular queue of free physical tags
// pop on dispatch, push on retire, rewind on squash
//**************************************************

`timescale 1ns/1ps
`default_nettype none

module free_list import rename_cfg_pkg::*; (
  input  logic             clock,
  input  logic             reset,
  input  logic             pop,
  input  logic             push,
  input  phys_tag_t        push_tag,
  input  logic             rewind,
  input  logic [rob_w:0]   rewind_count,
  output phys_tag_t        head_tag,
  output logic             empty,
  output logic [free_w:0]  count
);

  phys_tag_t tags [num_free];

  logic [free_w-1:0] rd_ptr;
  logic [free_w-1:0] wr_ptr;
  logic [free_w-1:0] rd_step;
  logic [free_w-1:0] rewind_step;
  logic [free_w:0]   count_up;
  logic [free_w:0]   count_down;

  // next tag to hand out, no registered read
  assign head_tag = tags[rd_ptr];
  assign empty    = (count == '0);

  assign rd_step     = pop ? free_w'(1) : '0;
  assign rewind_step = rewind ? free_w'(rewind_count) : '0;

  // squashed tags are still stored behind the read pointer
  assign count_up = (push ? (free_w + 1)'(1) : '0) +
                    (rewind ? (free_w + 1)'(rewind_count) : '0);
  assign count_down = pop ? (free_w + 1)'(1) : '0;

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= (free_w + 1)'(num_free);
      // queue starts full with the unmapped tags in order
      for (int i = 0; i < num_free; i++) begin
        tags[i] <= phys_tag_t'(free_base + i);
      end
    end else begin
      rd_ptr <= rd_ptr + rd_step - rewind_step;
      count  <= count + count_up - count_down;
      // retired T_old fills the slot a pop vacated
      if (push) begin
        tags[wr_ptr] <= push_tag;
        wr_ptr <= wr_ptr + free_w'(1);
      end
    end
  end

  // pop comes from the reorder buffer accept
  a_no_pop_empty: assert property (@(posedge clock) disable iff (reset)
    pop |-> !empty);

  // pushes plus rewinds never outrun what was popped
  a_count_bound: assert property (@(posedge clock) disable iff (reset)
    count <= num_free);

endmodule

`default_nettype wire

// ==== verilog/map_table.sv ====
//**************************************************
// map_table
// speculative arch to physical map
// one branch checkpoint with restore
//**************************************************

`timescale 1ns/1ps
`default_nettype none

module map_table import rename_cfg_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  arch_reg_t lookup,
  input  logic      write_en,
  input  arch_reg_t write_dest,
  input  phys_tag_t write_tag,
  input  logic      save,
  input  logic      restore,
  output phys_tag_t T_old
);

  phys_tag_t spec_map [num_arch];
  phys_tag_t ckpt_map [num_arch];
  phys_tag_t next_map [num_arch];

  // current mapping of the incoming destination
  assign T_old = spec_map[lookup];

  // map with this cycle's rename applied
  always_comb begin
    next_map = spec_map;
    if (write_en) begin
      next_map[write_dest] = write_tag;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_arch; i++) begin
        spec_map[i] <= phys_tag_t'(i);
        ckpt_map[i] <= phys_tag_t'(i);
      end
    end else begin
      // mispredict discards everything after the branch
      if (restore) begin
        spec_map <= ckpt_map;
      end else begin
        spec_map <= next_map;
      end
      // checkpoint includes the branch's own rename
      if (save) begin
        ckpt_map <= next_map;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/rob.sv ====
//**************************************************
// rob
// circular reorder buffer with head and tail pointers
// dispatch accept, in-order retire, branch squash
//**************************************************

`timescale 1ns/1ps
`default_nettype none

module rob import rename_cfg_pkg::*, rob_pkg::*; (
  input  logic          clock,
  input  logic          reset,
  input  dispatch_req_t dispatch,
  input  phys_tag_t     alloc_T,
  input  phys_tag_t     alloc_T_old,
  input  logic          retire_req,
  input  recover_t      recover,
  output logic          dispatch_fire,
  output rob_idx_t      tail_idx,
  output logic          full,
  output retire_t       retired,
  output logic [rob_w:0] squash_count
);

  rob_entry_t entries      [num_rob];
  rob_entry_t next_entries [num_rob];

  rob_idx_t head;
  rob_idx_t tail;
  rob_idx_t next_head;
  rob_idx_t next_tail;
  rob_idx_t squash_first;
  rob_idx_t squash_dist;

  logic retire_fire;
  logic [num_rob-1:0] squash_mask;

  // tail slot still occupied means it wrapped onto the head
  assign full     = entries[tail].valid;
  assign tail_idx = tail;

  assign retire_fire = retire_req && entries[head].valid;

  // a full buffer still takes one when the head leaves this cycle
  assign dispatch_fire = dispatch.valid && !recover.mispredict && (!full || retire_fire);

  assign retired = '{
    valid: retire_fire,
    dest:  entries[head].dest,
    T:     entries[head].T,
    T_old: entries[head].T_old
  };

  // entries from branch_idx + 1 up to the tail are squashed
  assign squash_first = recover.branch_idx + rob_idx_t'(1);
  assign squash_dist  = tail - squash_first;
  assign squash_count = {1'b0, squash_dist};

  // younger than the branch, wraparound in either direction
  always_comb begin
    squash_mask = '0;
    for (int i = 0; i < num_rob; i++) begin
      if (recover.branch_idx >= tail) begin
        squash_mask[i] = (i < tail) || (i > recover.branch_idx);
      end else begin
        squash_mask[i] = (i < tail) && (i > recover.branch_idx);
      end
    end
  end

  always_comb begin
    next_entries = entries;
    next_head    = head;
    next_tail    = tail;

    if (retire_fire) begin
      next_entries[head].valid = 1'b0;
      next_head = head + rob_idx_t'(1);
    end

    // after the retire so a write into the old head slot wins
    if (dispatch_fire) begin
      next_entries[tail] = '{
        valid: 1'b1,
        dest:  dispatch.dest,
        T:     alloc_T,
        T_old: alloc_T_old
      };
      next_tail = tail + rob_idx_t'(1);
    end

    if (recover.mispredict) begin
      for (int i = 0; i < num_rob; i++) begin
        if (squash_mask[i]) begin
          next_entries[i].valid = 1'b0;
        end
      end
      next_tail = squash_first;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
      for (int i = 0; i < num_rob; i++) begin
        entries[i].valid <= 1'b0;
      end
    end else begin
      head    <= next_head;
      tail    <= next_tail;
      entries <= next_entries;
    end
  end

  // writing a live slot is only legal when it is the head leaving
  a_no_overwrite: assert property (@(posedge clock) disable iff (reset)
    dispatch_fire && entries[tail].valid |-> retire_fire && (head == tail));

  // recovery must name an in-flight branch
  a_branch_live: assert property (@(posedge clock) disable iff (reset)
    recover.mispredict |-> entries[recover.branch_idx].valid);

endmodule

`default_nettype wire

// ==== verilog/arch_map.sv ====
//**************************************************
// arch_map
// committed arch to physical map
//**************************************************

`timescale 1ns/1ps
`default_nettype none

module arch_map import rename_cfg_pkg::*, rob_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  retire_t   retired,
  output phys_tag_t arch_tag,
  input  arch_reg_t arch_query
);

  phys_tag_t commit_map [num_arch];

  // committed mapping of any register, for observation
  assign arch_tag = commit_map[arch_query];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_arch; i++) begin
        commit_map[i] <= phys_tag_t'(i);
      end
    end else if (retired.valid) begin
      commit_map[retired.dest] <= retired.T;
    end
  end

  // T_old read at rename must be the committed tag it replaces
  a_told_matches: assert property (@(posedge clock) disable iff (reset)
    retired.valid |-> retired.T_old == commit_map[retired.dest]);

endmodule

`default_nettype wire

// ==== verilog/rename_core.sv ====
//**************************************************
// rename_core
// free list, map table, reorder buffer and
// retirement map wired into the rename subsystem
//**************************************************

`timescale 1ns/1ps
`default_nettype none

module rename_core import rename_cfg_pkg::*, rob_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  dispatch_req_t   dispatch,
  input  logic            retire_req,
  input  recover_t        recover,
  input  arch_reg_t       arch_query,
  output rename_t         renamed,
  output logic            dispatch_stall,
  output retire_t         retired,
  output logic [free_w:0] free_count,
  output phys_tag_t       arch_tag
);

  logic            dispatch_fire;
  logic            rob_full;
  logic            fl_empty;
  logic            ckpt_save;
  phys_tag_t       free_head;
  phys_tag_t       map_T_old;
  rob_idx_t        tail_idx;
  logic [rob_w:0]  squash_count;

  assign dispatch_stall = rob_full || fl_empty;

  // only an accepted branch takes the checkpoint
  assign ckpt_save = dispatch_fire && dispatch.is_branch;

  assign renamed = '{
    T:       free_head,
    T_old:   map_T_old,
    dest:    dispatch.dest,
    rob_idx: tail_idx
  };

  free_list u_free_list (
    .clock        (clock),
    .reset        (reset),
    .pop          (dispatch_fire),
    .push         (retired.valid),
    .push_tag     (retired.T_old),
    .rewind       (recover.mispredict),
    .rewind_count (squash_count),
    .head_tag     (free_head),
    .empty        (fl_empty),
    .count        (free_count)
  );

  map_table u_map_table (
    .clock      (clock),
    .reset      (reset),
    .lookup     (dispatch.dest),
    .write_en   (dispatch_fire),
    .write_dest (dispatch.dest),
    .write_tag  (free_head),
    .save       (ckpt_save),
    .restore    (recover.mispredict),
    .T_old      (map_T_old)
  );

  rob u_rob (
    .clock         (clock),
    .reset         (reset),
    .dispatch      (dispatch),
    .alloc_T       (free_head),
    .alloc_T_old   (map_T_old),
    .retire_req    (retire_req),
    .recover       (recover),
    .dispatch_fire (dispatch_fire),
    .tail_idx      (tail_idx),
    .full          (rob_full),
    .retired       (retired),
    .squash_count  (squash_count)
  );

  arch_map u_arch_map (
    .clock      (clock),
    .reset      (reset),
    .retired    (retired),
    .arch_tag   (arch_tag),
    .arch_query (arch_query)
  );

endmodule

`default_nettype wire

// ==== dv/rename_core_tb.sv ====
//**************************************************
// rename_core_tb
// clock, reset, directed and random stimulus
// queue reference model and concurrent checks
//**************************************************

`timescale 1ns/1ps
`default_nettype none

module rename_core_tb import rename_cfg_pkg::*, rob_pkg::*; ();

  localparam int clk_period      = 40;
  localparam int drive_delay     = 2;
  localparam int reset_cycles    = 5;
  localparam int directed_cycles = 53;
  localparam int random_cycles   = 400;
  // reset, directed part, random part, final drain and idle cycles
  localparam int test_cycles     = reset_cycles + directed_cycles + random_cycles +
                                   num_rob + 4;

  logic            clock;
  logic            reset;
  dispatch_req_t   dispatch;
  logic            retire_req;
  recover_t        recover;
  arch_reg_t       arch_query;
  rename_t         renamed;
  logic            dispatch_stall;
  retire_t         retired;
  logic [free_w:0] free_count;
  phys_tag_t       arch_tag;

  // reference model state
  rob_entry_t rob_q[$];
  phys_tag_t  free_q[$];
  phys_tag_t  spec_map   [num_arch];
  phys_tag_t  ckpt_map   [num_arch];
  phys_tag_t  commit_map [num_arch];
  int         model_head;
  int         model_tail;
  logic       branch_open;
  rob_idx_t   branch_at;
  arch_reg_t  last_dest;

  // expected outputs for the cycle being driven
  logic       exp_fire;
  logic       exp_retire;
  logic       exp_stall;
  phys_tag_t  exp_T;
  phys_tag_t  exp_T_old;
  rob_idx_t   exp_idx;
  rob_entry_t exp_head;
  int         exp_free;
  int         exp_in_flight;
  phys_tag_t  exp_arch_tag;

  int          error_count;
  int          rename_count;
  int          retire_count;
  int          recover_count;
  logic [31:0] rng_state;

  rename_core u_rename_core (
    .clock          (clock),
    .reset          (reset),
    .dispatch       (dispatch),
    .retire_req     (retire_req),
    .recover        (recover),
    .arch_query     (arch_query),
    .renamed        (renamed),
    .dispatch_stall (dispatch_stall),
    .retired        (retired),
    .free_count     (free_count),
    .arch_tag       (arch_tag)
  );

  always #(clk_period / 2) clock = ~clock;

  function automatic logic [31:0] xorshift32(input logic [31:0] value);
    logic [31:0] x;
    x = value;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic reset_model();
    rob_q.delete();
    free_q.delete();
    for (int i = 0; i < num_free; i++) begin
      free_q.push_back(phys_tag_t'(num_arch + i));
    end
    for (int i = 0; i < num_arch; i++) begin
      spec_map[i]   = phys_tag_t'(i);
      ckpt_map[i]   = phys_tag_t'(i);
      commit_map[i] = phys_tag_t'(i);
    end
    model_head  = 0;
    model_tail  = 0;
    branch_open = 1'b0;
    branch_at   = '0;
    last_dest   = '0;
  endtask

  task automatic update_model();
    logic       retire_go;
    logic       accept;
    int         squash_n;
    rob_entry_t entry;
    retire_go = retire_req && (rob_q.size() > 0);
    accept = dispatch.valid && !recover.mispredict &&
             ((rob_q.size() < num_rob) || retire_go);
    if (recover.mispredict) begin
      // everything behind the branch, counted from the head
      squash_n = rob_q.size() - 1 -
                 ((int'(recover.branch_idx) - model_head + num_rob) % num_rob);
      for (int k = 0; k < squash_n; k++) begin
        entry = rob_q.pop_back();
        free_q.push_front(entry.T);
      end
      spec_map      = ckpt_map;
      model_tail    = (int'(recover.branch_idx) + 1) % num_rob;
      branch_open   = 1'b0;
      recover_count = recover_count + 1;
    end
    if (retire_go) begin
      entry = rob_q.pop_front();
      free_q.push_back(entry.T_old);
      commit_map[entry.dest] = entry.T;
      last_dest = entry.dest;
      if (branch_open && (branch_at == rob_idx_t'(model_head))) begin
        branch_open = 1'b0;
      end
      model_head   = (model_head + 1) % num_rob;
      retire_count = retire_count + 1;
    end
    if (accept) begin
      entry.valid = 1'b1;
      entry.dest  = dispatch.dest;
      entry.T     = free_q.pop_front();
      entry.T_old = spec_map[dispatch.dest];
      rob_q.push_back(entry);
      spec_map[dispatch.dest] = entry.T;
      // checkpoint holds the map after the branch
      if (dispatch.is_branch) begin
        ckpt_map    = spec_map;
        branch_open = 1'b1;
        branch_at   = rob_idx_t'(model_tail);
      end
      model_tail   = (model_tail + 1) % num_rob;
      rename_count = rename_count + 1;
    end
  endtask

  task automatic compute_expected();
    exp_retire = retire_req && (rob_q.size() > 0);
    exp_fire = dispatch.valid && !recover.mispredict &&
               ((rob_q.size() < num_rob) || exp_retire);
    exp_stall     = (rob_q.size() == num_rob) || (free_q.size() == 0);
    exp_T         = (free_q.size() > 0) ? free_q[0] : '0;
    exp_T_old     = spec_map[dispatch.dest];
    exp_idx       = rob_idx_t'(model_tail);
    exp_head      = (rob_q.size() > 0) ? rob_q[0] : '0;
    exp_free      = free_q.size();
    exp_in_flight = rob_q.size();
    exp_arch_tag  = commit_map[arch_query];
  endtask

  always @(posedge clock) begin
    if (reset) begin
      reset_model();
    end else begin
      update_model();
    end
  end

  task automatic next_cycle();
    @(posedge clock);
    #(drive_delay);
  endtask

  task automatic apply_inputs(input logic valid, input arch_reg_t dest, input logic is_branch,
                              input logic retire, input logic mispredict,
                              input rob_idx_t branch_idx, input arch_reg_t query);
    dispatch.valid      = valid;
    dispatch.dest       = dest;
    dispatch.is_branch  = is_branch;
    retire_req          = retire;
    recover.mispredict  = mispredict;
    recover.branch_idx  = branch_idx;
    arch_query          = query;
    compute_expected();
  endtask

  task automatic send(input arch_reg_t dest, input logic is_branch, input logic retire);
    next_cycle();
    apply_inputs(1'b1, dest, is_branch, retire, 1'b0, '0, last_dest);
  endtask

  task automatic retire_only(input int cycles);
    repeat (cycles) begin
      next_cycle();
      apply_inputs(1'b0, '0, 1'b0, 1'b1, 1'b0, '0, last_dest);
    end
  endtask

  task automatic mispredict_at(input rob_idx_t idx);
    next_cycle();
    apply_inputs(1'b0, '0, 1'b0, 1'b0, 1'b1, idx, last_dest);
  endtask

  // decisions use the model state after the latest edge
  task automatic random_cycle();
    logic [31:0] r;
    next_cycle();
    rng_state = xorshift32(rng_state);
    r = rng_state;
    apply_inputs(r[1:0] != 2'b00, arch_reg_t'(r[10:6]),
                 !branch_open && (r[13:11] == 3'd0), r[2],
                 branch_open && (r[17:14] == 4'd0), branch_at, arch_reg_t'(r[22:18]));
  endtask

  a_rename_T: assert property (@(posedge clock) disable iff (reset)
    exp_fire |-> renamed.T == exp_T)
    else begin
      error_count++;
      $display("[FAIL] %0t: renamed.T %0d, expected %0d", $time,
               $sampled(renamed.T), $sampled(exp_T));
    end

  a_rename_T_old: assert property (@(posedge clock) disable iff (reset)
    exp_fire |-> renamed.T_old == exp_T_old)
    else begin
      error_count++;
      $display("[FAIL] %0t: renamed.T_old %0d, expected %0d", $time,
               $sampled(renamed.T_old), $sampled(exp_T_old));
    end

  a_rename_dest: assert property (@(posedge clock) disable iff (reset)
    exp_fire |-> renamed.dest == dispatch.dest)
    else begin
      error_count++;
      $display("[FAIL] %0t: renamed.dest r%0d, expected r%0d", $time,
               $sampled(renamed.dest), $sampled(dispatch.dest));
    end

  a_rename_idx: assert property (@(posedge clock) disable iff (reset)
    exp_fire |-> renamed.rob_idx == exp_idx)
    else begin
      error_count++;
      $display("[FAIL] %0t: renamed.rob_idx %0d, expected %0d", $time,
               $sampled(renamed.rob_idx), $sampled(exp_idx));
    end

  a_stall: assert property (@(posedge clock) disable iff (reset)
    dispatch_stall == exp_stall)
    else begin
      error_count++;
      $display("[FAIL] %0t: dispatch_stall %0b, expected %0b", $time,
               $sampled(dispatch_stall), $sampled(exp_stall));
    end

  a_retire_valid: assert property (@(posedge clock) disable iff (reset)
    retired.valid == exp_retire)
    else begin
      error_count++;
      $display("[FAIL] %0t: retired.valid %0b, expected %0b", $time,
               $sampled(retired.valid), $sampled(exp_retire));
    end

  // oldest entry leaves with the tags it was renamed with
  a_retire_entry: assert property (@(posedge clock) disable iff (reset)
    exp_retire |-> retired.dest == exp_head.dest && retired.T == exp_head.T &&
                   retired.T_old == exp_head.T_old)
    else begin
      error_count++;
      $display("[FAIL] %0t: retired r%0d T %0d T_old %0d, expected r%0d T %0d T_old %0d",
               $time, $sampled(retired.dest), $sampled(retired.T), $sampled(retired.T_old),
               $sampled(exp_head.dest), $sampled(exp_head.T), $sampled(exp_head.T_old));
    end

  a_free_count: assert property (@(posedge clock) disable iff (reset)
    int'(free_count) == exp_free)
    else begin
      error_count++;
      $display("[FAIL] %0t: free_count %0d, expected %0d", $time,
               $sampled(free_count), $sampled(exp_free));
    end

  a_arch_tag: assert property (@(posedge clock) disable iff (reset)
    arch_tag == exp_arch_tag)
    else begin
      error_count++;
      $display("[FAIL] %0t: arch_tag %0d, expected %0d", $time,
               $sampled(arch_tag), $sampled(exp_arch_tag));
    end

  // free tags and in-flight tags cover the whole free pool
  a_tag_total: assert property (@(posedge clock) disable iff (reset)
    int'(free_count) + exp_in_flight == num_free)
    else begin
      error_count++;
      $display("[FAIL] %0t: free_count %0d and %0d in flight, expected %0d in total",
               $time, $sampled(free_count), $sampled(exp_in_flight), num_free);
    end

  initial begin
    clock         = 1'b0;
    reset         = 1'b1;
    dispatch      = '0;
    retire_req    = 1'b0;
    recover       = '0;
    arch_query    = '0;
    error_count   = 0;
    rename_count  = 0;
    retire_count  = 0;
    recover_count = 0;
    rng_state     = 32'hee49;
    reset_model();
    compute_expected();
    repeat (reset_cycles) @(posedge clock);
    #(drive_delay);
    reset = 1'b0;
    compute_expected();

    // fresh tags in order, then r1 renamed a second time
    send(5'd1, 1'b0, 1'b0);
    send(5'd2, 1'b0, 1'b0);
    send(5'd1, 1'b0, 1'b0);
    send(5'd3, 1'b0, 1'b0);
    for (int i = 0; i < 12; i++) begin
      send(arch_reg_t'(i + 4), 1'b0, 1'b0);
    end
    // buffer full, plain dispatch held off, dispatch with retire taken
    send(5'd9, 1'b0, 1'b0);
    send(5'd10, 1'b0, 1'b1);
    retire_only(6);

    // branch with younger renames, then squash and reuse
    send(5'd5, 1'b1, 1'b0);
    send(5'd5, 1'b0, 1'b0);
    send(5'd6, 1'b0, 1'b0);
    send(5'd7, 1'b0, 1'b0);
    send(5'd5, 1'b0, 1'b0);
    mispredict_at(branch_at);
    send(5'd5, 1'b0, 1'b0);
    send(5'd6, 1'b0, 1'b0);
    send(5'd8, 1'b0, 1'b0);
    retire_only(20);

    repeat (random_cycles) begin
      random_cycle();
    end
    retire_only(num_rob + 2);
    next_cycle();
    apply_inputs(1'b0, '0, 1'b0, 1'b0, 1'b0, '0, last_dest);
    next_cycle();

    $display("errors: %0d, renames: %0d, retires: %0d, recoveries: %0d",
             error_count, rename_count, retire_count, recover_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // bound on the whole run with some slack
  initial begin
    #((test_cycles + 50) * clk_period);
    $display("watchdog expired after %0d cycles, run did not finish", test_cycles + 50);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rename_core.f ====
verilog/rename_cfg_pkg.sv
verilog/rob_pkg.sv
verilog/free_list.sv
verilog/map_table.sv
verilog/rob.sv
verilog/arch_map.sv
verilog/rename_core.sv
dv/rename_core_tb.sv

// ==== Bender.yml ====
package:
  name: rename_core

sources:
  - verilog/rename_cfg_pkg.sv
  - verilog/rob_pkg.sv
  - verilog/free_list.sv
  - verilog/map_table.sv
  - verilog/rob.sv
  - verilog/arch_map.sv
  - verilog/rename_core.sv
  - target: simulation
    files:
      - dv/rename_core_tb.sv
